// File: Bender.yml
package:
  name: dct_row

sources:
  # package first, then leaf blocks and the top level
  - src/dct_pkg.sv
  - src/pixel_row_collector.sv
  - src/dct16_row_core.sv
  - src/coef_serializer.sv
  - src/dct_row_top.sv
  - target: test
    files:
      - testbench/tb_dct_row.sv

// File: compile.f
src/dct_pkg.sv
src/pixel_row_collector.sv
src/dct16_row_core.sv
src/coef_serializer.sv
src/dct_row_top.sv
testbench/tb_dct_row.sv

// File: src/coef_serializer.sv
// coef_serializer: two coefficient row buffers, in-order coefficient output, output credit count
`default_nettype none

module coef_serializer import dct_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  coef_row_t row_out,
    input  logic      row_out_valid,
    output logic      row_out_ready,
    output logic      coef_valid,
    output coef_t     coef_data,
    output coef_idx_t coef_index,
    input  logic      out_credit
);

    localparam int CRED_W = $clog2(OUT_CREDITS + 1);

    coef_row_t         row_buf [2];
    logic [1:0]        full_q;
    logic              wr_sel;
    logic              rd_sel;
    coef_idx_t         rd_idx;
    logic [CRED_W-1:0] credit_cnt;
    logic              row_acc;
    logic              send;

    // accept whenever the next write buffer is free
    assign row_out_ready = !full_q[wr_sel];
    assign row_acc       = row_out_valid && row_out_ready;

    // one coefficient per cycle while a credit is held
    assign send       = full_q[rd_sel] && (credit_cnt != '0);
    assign coef_valid = send;
    assign coef_data  = row_buf[rd_sel].coef[rd_idx];
    assign coef_index = rd_idx;

    // coefficient row storage
    always_ff @(posedge clk) begin
        if (row_acc) begin
            row_buf[wr_sel] <= row_out;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            full_q     <= '0;
            wr_sel     <= 1'b0;
            rd_sel     <= 1'b0;
            rd_idx     <= '0;
            credit_cnt <= CRED_W'(OUT_CREDITS);
        end else begin
            if (row_acc) begin
                full_q[wr_sel] <= 1'b1;
                wr_sel         <= ~wr_sel;
            end
            if (send) begin
                rd_idx <= rd_idx + 1'b1;
                // last index frees the buffer
                if (rd_idx == coef_idx_t'(ROW_LEN - 1)) begin
                    full_q[rd_sel] <= 1'b0;
                    rd_sel         <= ~rd_sel;
                end
            end
            credit_cnt <= credit_cnt + CRED_W'(out_credit) - CRED_W'(send);
        end
    end

endmodule

`default_nettype wire

// File: src/dct16_row_core.sv
// dct16_row_core: three-stage butterfly 16-point row DCT with whole-pipeline stall
`default_nettype none

module dct16_row_core import dct_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  pixel_row_t row_in,
    input  logic       row_in_valid,
    output logic       row_in_ready,
    output coef_row_t  row_out,
    output logic       row_out_valid,
    input  logic       row_out_ready
);

    // butterfly level widths, each one bit wider than the last
    typedef logic signed [9:0]  lvl1_t;
    typedef logic signed [10:0] lvl2_t;
    typedef logic signed [11:0] lvl3_t;
    typedef logic signed [12:0] lvl4_t;
    typedef logic signed [17:0] prod_t;
    typedef logic signed [19:0] acc_t;

    // signed operand times unsigned 1.6 constant
    function automatic prod_t cmul(input prod_t a, input cos_t c);
        prod_t cc;
        cc = prod_t'(c);
        return a * cc;
    endfunction

    // fold angle index (units of pi/32) into table index 0..16
    function automatic int fold_idx(input int angle);
        int a;
        a = angle % 64;
        if (a > 32) a = 64 - a;
        if (a > 16) a = 32 - a;
        return a;
    endfunction

    // cosine sign of the same angle
    function automatic bit fold_neg(input int angle);
        int a;
        a = angle % 64;
        if (a > 32) a = 64 - a;
        return (a > 16);
    endfunction

    logic      v1_q, v2_q, v3_q;
    logic      advance;
    lvl1_t     s1_sum [8];
    lvl1_t     s1_dif [8];
    lvl2_t     s1_ee  [4];
    lvl2_t     s1_eo  [4];
    lvl1_t     d_q    [8];
    lvl2_t     ee_q   [4];
    lvl2_t     eo_q   [4];
    lvl3_t     eee    [2];
    lvl3_t     eeo    [2];
    lvl4_t     e0_q, e8_q;
    prod_t     p_eeo_q [2][2];
    prod_t     p_eo_q  [4][4];
    prod_t     p_odd_q [8][8];
    coef_row_t coef_d;
    coef_row_t coef_q;

    // freeze everything while the output row is held
    assign advance       = !(v3_q && !row_out_ready);
    assign row_in_ready  = advance;
    assign row_out_valid = v3_q;
    assign row_out       = coef_q;

    // levels 1 and 2: pair butterflies, then even-part butterflies
    always_comb begin
        for (int n = 0; n < 8; n++) begin
            s1_sum[n] = lvl1_t'(row_in.pix[n]) + lvl1_t'(row_in.pix[15-n]);
            s1_dif[n] = lvl1_t'(row_in.pix[n]) - lvl1_t'(row_in.pix[15-n]);
        end
        for (int n = 0; n < 4; n++) begin
            s1_ee[n] = s1_sum[n] + s1_sum[7-n];
            s1_eo[n] = s1_sum[n] - s1_sum[7-n];
        end
    end

    // level 3 of the even-even part
    always_comb begin
        for (int n = 0; n < 2; n++) begin
            eee[n] = ee_q[n] + ee_q[3-n];
            eeo[n] = ee_q[n] - ee_q[3-n];
        end
    end

    // accumulation with folded signs, truncate to bits 16..6
    always_comb begin
        acc_t acc;
        acc_t term;
        int   ang;
        acc = cmul(e0_q, COS_TABLE[8]);
        coef_d.coef[0] = acc[16:6];
        acc = cmul(e8_q, COS_TABLE[8]);
        coef_d.coef[8] = acc[16:6];
        // X4, X12 from C4 / C12 products
        for (int i = 0; i < 2; i++) begin
            acc = '0;
            for (int n = 0; n < 2; n++) begin
                ang  = (2 * n + 1) * (8 * i + 4);
                term = p_eeo_q[n][(fold_idx(ang) - 4) / 8];
                acc  = fold_neg(ang) ? acc - term : acc + term;
            end
            coef_d.coef[8 * i + 4] = acc[16:6];
        end
        // X2, X6, X10, X14
        for (int i = 0; i < 4; i++) begin
            acc = '0;
            for (int n = 0; n < 4; n++) begin
                ang  = (2 * n + 1) * (4 * i + 2);
                term = p_eo_q[n][(fold_idx(ang) - 2) / 4];
                acc  = fold_neg(ang) ? acc - term : acc + term;
            end
            coef_d.coef[4 * i + 2] = acc[16:6];
        end
        // odd coefficients
        for (int i = 0; i < 8; i++) begin
            acc = '0;
            for (int n = 0; n < 8; n++) begin
                ang  = (2 * n + 1) * (2 * i + 1);
                term = p_odd_q[n][(fold_idx(ang) - 1) / 2];
                acc  = fold_neg(ang) ? acc - term : acc + term;
            end
            coef_d.coef[2 * i + 1] = acc[16:6];
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        if (advance) begin
            d_q  <= s1_dif;
            ee_q <= s1_ee;
            eo_q <= s1_eo;
            e0_q <= eee[0] + eee[1];
            e8_q <= eee[0] - eee[1];
            for (int n = 0; n < 2; n++) begin
                for (int j = 0; j < 2; j++) begin
                    p_eeo_q[n][j] <= cmul(eeo[n], COS_TABLE[8 * j + 4]);
                end
            end
            for (int n = 0; n < 4; n++) begin
                for (int j = 0; j < 4; j++) begin
                    p_eo_q[n][j] <= cmul(eo_q[n], COS_TABLE[4 * j + 2]);
                end
            end
            for (int n = 0; n < 8; n++) begin
                for (int j = 0; j < 8; j++) begin
                    p_odd_q[n][j] <= cmul(d_q[n], COS_TABLE[2 * j + 1]);
                end
            end
            coef_q <= coef_d;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
            v3_q <= 1'b0;
        end else if (advance) begin
            v1_q <= row_in_valid;
            v2_q <= v1_q;
            v3_q <= v2_q;
        end
    end

endmodule

`default_nettype wire

// File: src/dct_pkg.sv
// widths, pixel and coefficient types, row structs, cosine table, credit depths
`default_nettype none

package dct_pkg;

    // data widths
    localparam int PIX_W  = 8;
    localparam int COEF_W = 11;
    localparam int COS_W  = 7;
    localparam int IDX_W  = 4;

    // points per row
    localparam int ROW_LEN = 16;

    // sender credits after reset, two row buffers worth
    localparam int IN_CREDITS = 32;
    // coefficient credits held after reset
    localparam int OUT_CREDITS = 4;

    typedef logic        [PIX_W-1:0]  pixel_t;
    typedef logic signed [COEF_W-1:0] coef_t;
    typedef logic        [COS_W-1:0]  cos_t;
    typedef logic        [IDX_W-1:0]  coef_idx_t;

    // sqrt(2/16) * cos(k*pi/32) in 1.6 format, k = 1..15
    // C8 also stands in for C0
    localparam cos_t COS_TABLE [1:15] = '{
        7'd23, 7'd22, 7'd22, 7'd21, 7'd20, 7'd19, 7'd17, 7'd16,
        7'd14, 7'd13, 7'd11, 7'd9,  7'd7,  7'd4,  7'd2
    };

    // pixel 0 sits in the top byte
    typedef struct packed {
        pixel_t [0:ROW_LEN-1] pix;
    } pixel_row_t;

    // coefficient 0 sits in the top 11 bits
    typedef struct packed {
        coef_t [0:ROW_LEN-1] coef;
    } coef_row_t;

endpackage

`default_nettype wire

// File: src/dct_row_top.sv
// dct_row_top: collector, row DCT core and serializer joined by two row handshakes
`default_nettype none

module dct_row_top import dct_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      pix_valid,
    input  pixel_t    pix_data,
    output logic      in_credit,
    output logic      coef_valid,
    output coef_t     coef_data,
    output coef_idx_t coef_index,
    input  logic      out_credit
);

    // collector to core
    pixel_row_t row_in;
    logic       row_in_valid;
    logic       row_in_ready;

    // core to serializer
    coef_row_t  row_out;
    logic       row_out_valid;
    logic       row_out_ready;

    pixel_row_collector u_collector (
        .clk          (clk),
        .reset        (reset),
        .pix_valid    (pix_valid),
        .pix_data     (pix_data),
        .in_credit    (in_credit),
        .row_in       (row_in),
        .row_in_valid (row_in_valid),
        .row_in_ready (row_in_ready)
    );

    dct16_row_core u_core (
        .clk           (clk),
        .reset         (reset),
        .row_in        (row_in),
        .row_in_valid  (row_in_valid),
        .row_in_ready  (row_in_ready),
        .row_out       (row_out),
        .row_out_valid (row_out_valid),
        .row_out_ready (row_out_ready)
    );

    coef_serializer u_serializer (
        .clk           (clk),
        .reset         (reset),
        .row_out       (row_out),
        .row_out_valid (row_out_valid),
        .row_out_ready (row_out_ready),
        .coef_valid    (coef_valid),
        .coef_data     (coef_data),
        .coef_index    (coef_index),
        .out_credit    (out_credit)
    );

endmodule

`default_nettype wire

// File: src/pixel_row_collector.sv
// pixel_row_collector: pixel stream into two row buffers, row handshake, input credit return
`default_nettype none

module pixel_row_collector import dct_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       pix_valid,
    input  pixel_t     pix_data,
    output logic       in_credit,
    output pixel_row_t row_in,
    output logic       row_in_valid,
    input  logic       row_in_ready
);

    localparam int PEND_W = $clog2(IN_CREDITS + 1);

    pixel_row_t        row_buf [2];
    logic [1:0]        full_q;
    logic              fill_sel;
    logic              rd_sel;
    coef_idx_t         wr_pos;
    logic [PEND_W-1:0] pend_cnt;
    logic              last_pix;
    logic              row_xfer;

    assign last_pix = pix_valid && (wr_pos == coef_idx_t'(ROW_LEN - 1));

    // oldest full buffer goes to the core
    assign row_in       = row_buf[rd_sel];
    assign row_in_valid = full_q[rd_sel];
    assign row_xfer     = row_in_valid && row_in_ready;

    // one credit per cycle while slots are pending
    assign in_credit = (pend_cnt != '0);

    // pixel storage
    always_ff @(posedge clk) begin
        if (pix_valid) begin
            row_buf[fill_sel].pix[wr_pos] <= pix_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            full_q   <= '0;
            fill_sel <= 1'b0;
            rd_sel   <= 1'b0;
            wr_pos   <= '0;
            pend_cnt <= '0;
        end else begin
            if (pix_valid) begin
                wr_pos <= wr_pos + 1'b1;
            end
            // 16th pixel closes the row, switch to the other buffer
            if (last_pix) begin
                full_q[fill_sel] <= 1'b1;
                fill_sel         <= ~fill_sel;
            end
            if (row_xfer) begin
                full_q[rd_sel] <= 1'b0;
                rd_sel         <= ~rd_sel;
            end
            // freed slots return one by one
            pend_cnt <= pend_cnt + (row_xfer ? PEND_W'(ROW_LEN) : PEND_W'(0))
                        - PEND_W'(in_credit);
        end
    end

endmodule

`default_nettype wire

// File: testbench/dct_row_stimulus.txt
// each test row: 16 pixel values x0..x15 (hex), then its 16 expected coefficients X0..X15
// coefficients are 11-bit two's complement hex, bits 16..6 of sum over n of x_n * signed cosine
// row 0: flat 0x80
80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
200 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
// row 1: impulse 0xFF at pixel 0
FF 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
03F 05B 057 057 053 04F 04B 043 03F 037 033 02B 023 01B 00F 007
// row 2: impulse 0xFF at pixel 15
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 FF
03F 7A4 057 7A8 053 7B0 04B 7BC 03F 7C8 033 7D4 023 7E4 00F 7F8
// row 3: step, first half 0xFF
FF FF FF FF FF FF FF FF 00 00 00 00 00 00 00 00
1FE 1CE 000 760 000 05F 000 7B8 000 037 000 7C8 000 037 000 7D0
// row 4: flat 0xFF
FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF
3FC 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
// row 5: all zero
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000

// File: testbench/tb_dct_row.sv
// dct_row_top testbench with clock, reset, credit-paced stimulus rows, LFSR pacing and checks
`default_nettype none

module tb_dct_row import dct_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS   = 6;
    localparam int ROW_WORDS  = 2 * ROW_LEN;
    localparam int WAIT_LIMIT = 5000;

    logic        clk;
    logic        reset;
    logic        pix_valid;
    pixel_t      pix_data;
    logic        in_credit;
    logic        coef_valid;
    coef_t       coef_data;
    coef_idx_t   coef_index;
    logic        out_credit;

    // 16 pixels then 16 expected coefficients per row
    logic [11:0] stim_mem [0:NUM_ROWS*ROW_WORDS-1];

    pixel_t      pix_q [$];
    coef_t       rx_coef_q [$];
    coef_idx_t   rx_idx_q [$];
    int          pix_issued;
    int          in_seen;
    int          rx_total;
    int          out_returned;
    int          errors;
    int          tests_passed;
    int          tests_failed;
    bit          pace_random;
    logic [15:0] lfsr_state;

    dct_row_top DUT (
        .clk        (clk),
        .reset      (reset),
        .pix_valid  (pix_valid),
        .pix_data   (pix_data),
        .in_credit  (in_credit),
        .coef_valid (coef_valid),
        .coef_data  (coef_data),
        .coef_index (coef_index),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fibonacci taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic check_coef(input coef_t got, input coef_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s coefficient %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_index(input coef_idx_t got, input coef_idx_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s index %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run(input string reason);
        $display("timeout: %s", reason);
        $display("sim failed");
        $finish;
    endtask

    task automatic wait_coefs(input int count, input string what);
        int cycles;
        cycles = 0;
        while (rx_coef_q.size() < count && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (rx_coef_q.size() < count) begin
            abort_run($sformatf("%s got only %0d of %0d coefficients",
                                what, rx_coef_q.size(), count));
        end
    endtask

    task automatic queue_rows(input int first, input int count);
        for (int r = first; r < first + count; r++) begin
            for (int p = 0; p < ROW_LEN; p++) begin
                pix_q.push_back(pixel_t'(stim_mem[r * ROW_WORDS + p][7:0]));
            end
        end
    endtask

    task automatic check_rows(input int first, input int count);
        coef_t exp;
        for (int r = first; r < first + count; r++) begin
            for (int k = 0; k < ROW_LEN; k++) begin
                exp = coef_t'(stim_mem[r * ROW_WORDS + ROW_LEN + k][10:0]);
                check_coef(rx_coef_q.pop_front(), exp, $sformatf("row %0d k %0d", r, k));
                check_index(rx_idx_q.pop_front(), coef_idx_t'(k),
                            $sformatf("row %0d k %0d", r, k));
            end
        end
    endtask

    task automatic finish_test(input int num, input string name, input int err_mark);
        if (errors == err_mark) begin
            $display("test %0d %s: ok", num, name);
            tests_passed++;
        end else begin
            $display("test %0d %s: FAIL with %0d errors", num, name, errors - err_mark);
            tests_failed++;
        end
    endtask

    // sends one pixel per held credit
    always @(posedge clk) begin
        if (reset) begin
            pix_valid <= 1'b0;
            pix_data  <= '0;
        end else begin
            if (in_credit) begin
                in_seen++;
                if (in_seen > pix_issued) begin
                    $display("ERR %0t: in_credit pulse beyond pixels sent", $time);
                    errors++;
                end
            end
            if (pix_q.size() > 0 && pix_issued < IN_CREDITS + in_seen) begin
                pix_valid <= 1'b1;
                pix_data  <= pix_q.pop_front();
                pix_issued++;
            end else begin
                pix_valid <= 1'b0;
            end
        end
    end

    // receiver collects coefficients and returns credits
    always @(posedge clk) begin
        if (reset) begin
            out_credit <= 1'b0;
        end else begin
            if (coef_valid) begin
                rx_coef_q.push_back(coef_data);
                rx_idx_q.push_back(coef_index);
                rx_total++;
                if (rx_total > OUT_CREDITS + out_returned) begin
                    $display("ERR %0t: %0d coefficients against %0d returned credits",
                             $time, rx_total, out_returned);
                    errors++;
                end
            end
            if (out_credit) begin
                out_returned++;
            end
            if (rx_total > out_returned) begin
                if (pace_random) begin
                    lfsr_state = lfsr_step(lfsr_state);
                    out_credit <= lfsr_state[0];
                end else begin
                    out_credit <= 1'b1;
                end
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    initial begin
        int err_mark;
        int cycles;
        reset        = 1'b1;
        pix_valid    = 1'b0;
        pix_data     = '0;
        out_credit   = 1'b0;
        pix_issued   = 0;
        in_seen      = 0;
        rx_total     = 0;
        out_returned = 0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        pace_random  = 1'b0;
        lfsr_state   = 16'd19504;
        $readmemh("testbench/dct_row_stimulus.txt", stim_mem);
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // both outputs stay quiet with nothing sent
        err_mark = errors;
        repeat (16) begin
            @(negedge clk);
            if (coef_valid !== 1'b0 || in_credit !== 1'b0) begin
                $display("ERR %0t: output active with no pixels sent", $time);
                errors++;
            end
        end
        finish_test(1, "after reset", err_mark);

        err_mark = errors;
        queue_rows(0, 1);
        wait_coefs(ROW_LEN, "flat row");
        check_rows(0, 1);
        finish_test(2, "flat row", err_mark);

        err_mark = errors;
        queue_rows(0, NUM_ROWS);
        wait_coefs(NUM_ROWS * ROW_LEN, "free credit rows");
        check_rows(0, NUM_ROWS);
        finish_test(3, "free credit rows", err_mark);

        err_mark = errors;
        pace_random = 1'b1;
        queue_rows(0, NUM_ROWS);
        wait_coefs(NUM_ROWS * ROW_LEN, "paced credit rows");
        check_rows(0, NUM_ROWS);
        finish_test(4, "output back-pressure", err_mark);

        // every pixel slot must come back as an in_credit pulse
        err_mark = errors;
        cycles = 0;
        while ((in_seen != pix_issued || pix_q.size() != 0) && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (in_seen != pix_issued || pix_q.size() != 0) begin
            abort_run($sformatf("only %0d of %0d input credits returned", in_seen, pix_issued));
        end
        // drained, so no further credits or coefficients
        repeat (ROW_LEN) begin
            @(negedge clk);
            if (in_credit !== 1'b0 || coef_valid !== 1'b0) begin
                $display("ERR %0t: output active after all rows drained", $time);
                errors++;
            end
        end
        if (rx_coef_q.size() != 0) begin
            $display("ERR %0t: %0d unexpected extra coefficients", $time, rx_coef_q.size());
            errors++;
        end
        finish_test(5, "input credit return", err_mark);

        $display("tests: %0d ok, %0d failing", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
